/* src.f */
hdl/mipsIsaPkg.sv
hdl/decodeCtrlPkg.sv
hdl/aluCtrlDecode.sv
hdl/regFlowDecode.sv
hdl/decodeIssue.sv
hdl/decodeTop.sv
dv/decodeTb.sv

/* Makefile */
# Verilator build and run of the decode stage testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module decodeTb -f src.f
	./obj_dir/VdecodeTb

clean:
	rm -rf obj_dir

/* dv/decodeTrace.txt */
// instr immExt aluOp branchType regWaddr rsAddr rtAddr shamt flags
// flag digits: aluSelA aluSelB memEn memRead memWrite memToReg regWen linkPc8 undefinedInst
00221820 00001820 07 0 03 01 02 00 000000100 // add $3,$1,$2
00a62023 00002023 0a 0 04 05 06 00 000000100 // subu $4,$5,$6
01093827 00003827 04 0 07 08 09 00 000000100 // nor $7,$8,$9
00031100 00001100 0b 0 02 00 03 04 100000100 // sll $2,$3,4
00062fc3 00002fc3 0f 0 05 00 06 1f 100000100 // sra $5,$6,31
00620806 00000806 0e 0 01 03 02 00 000000100 // srlv $1,$2,$3
2149fffc fffffffc 07 0 09 0a 00 1f 010000100 // addi $9,$10,-4
24031234 00001234 08 0 03 00 00 08 010000100 // addiu $3,$0,0x1234
28a4ffff ffffffff 05 0 04 05 00 1f 010000100 // slti $4,$5,-1
30e68001 00008001 01 0 06 07 00 00 010000100 // andi $6,$7,0x8001
3528f0f0 0000f0f0 02 0 08 09 00 03 010000100 // ori $8,$9,0xf0f0
3821ffff 0000ffff 03 0 01 01 00 1f 010000100 // xori $1,$1,0xffff
3c02abcd 0000abcd 11 0 02 00 00 0f 010000100 // lui $2,0xabcd
8fa5fff8 fffffff8 08 0 05 1d 00 1f 011101100 // lw $5,-8($29)
90860003 00000003 08 0 06 04 00 00 011101100 // lbu $6,3($4)
afa90004 00000004 08 0 00 1d 09 00 011010000 // sw $9,4($29)
a043ffff ffffffff 08 0 1f 02 03 1f 011010000 // sb $3,-1($2)
1022fffe fffffffe 00 3 1f 01 02 1f 000000000 // beq $1,$2,-2
1c600008 00000008 00 5 00 03 00 00 000000000 // bgtz $3,8
08100040 00000040 00 1 00 00 00 01 000000000 // j 0x0100040
0c000123 00000123 00 1 1f 00 00 04 000000110 // jal 0x0000123
03e00008 00000008 00 2 00 1f 00 00 000000000 // jr $31
0080f809 fffff809 00 2 1f 04 00 00 000000110 // jalr $31,$4
04b0fffc fffffffc 00 8 1f 05 00 1f 000000110 // bltzal $5,-4
04d10010 00000010 00 7 1f 06 00 00 000000110 // bgezal $6,16
04e1000c 0000000c 00 7 00 07 01 00 000000000 // bgez $7,12
00850018 00000018 00 0 00 04 05 00 000000001 // mult $4,$5
40086000 00006000 00 0 0c 00 08 00 000000001 // mfc0 $8,$12
70432002 00002002 00 0 04 02 03 00 000000001 // mul $4,$2,$3
04680005 00000005 00 0 00 03 08 00 000000001 // tgei $3,5

/* dv/decodeTb.sv */
`default_nettype none

module decodeTb;
    timeunit 1ns;
    timeprecision 1ps;

    import mipsIsaPkg::*;
    import decodeCtrlPkg::*;

    localparam int QueueDepth = 4;
    localparam int traceLen   = 30;
    localparam int fieldsPer  = 9;  // hex words per trace line
    localparam int clkPeriod  = 10;

    logic                    clk;
    logic                    arstN;
    logic [instrWidth-1:0]   instr;
    logic                    instrValid;
    logic                    instrReady;
    logic                    creditReturn;
    logic                    decValid;
    aluOpE                   aluOp;
    logic                    aluSelA;
    logic                    aluSelB;
    logic                    memEn;
    logic                    memRead;
    logic                    memWrite;
    logic                    memToReg;
    logic                    regWen;
    logic [regAddrWidth-1:0] regWaddr;
    logic [regAddrWidth-1:0] rsAddr;
    logic [regAddrWidth-1:0] rtAddr;
    logic [shamtWidth-1:0]   shamt;
    logic [dataWidth-1:0]    immExt;
    branchTypeE              branchType;
    logic                    linkPc8;
    logic                    undefinedInst;

    logic [35:0] traceMem [traceLen*fieldsPer];
    logic [31:0] rngState;
    int          modelCredits;
    int          inQueue;   // delivered but not yet freed
    int          accepted;
    int          returned;
    int          checked;
    logic        xferPrev;

    decodeTop #(.QueueDepth(QueueDepth)) dut0 (.*);

    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic logic [31:0] traceField(input int entry, input int pos);
        return traceMem[entry*fieldsPer + pos][31:0];
    endfunction

    // one hex digit per flag with aluSelA on top
    function automatic logic [31:0] flagAt(input int entry, input int pos);
        logic [35:0] flags;
        flags = traceMem[entry*fieldsPer + 8];
        return 32'(flags[4*(8-pos)]);
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic checkField(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected)
        else failRun($sformatf("Mismatch %s: expected %h, got %h", name, expected, actual));
    endtask

    task automatic checkBundle(input int e);
        checkField("immExt", traceField(e, 1), immExt);
        checkField("aluOp", traceField(e, 2), 32'(aluOp));
        checkField("branchType", traceField(e, 3), 32'(branchType));
        checkField("regWaddr", traceField(e, 4), 32'(regWaddr));
        checkField("rsAddr", traceField(e, 5), 32'(rsAddr));
        checkField("rtAddr", traceField(e, 6), 32'(rtAddr));
        checkField("shamt", traceField(e, 7), 32'(shamt));
        checkField("aluSelA", flagAt(e, 0), 32'(aluSelA));
        checkField("aluSelB", flagAt(e, 1), 32'(aluSelB));
        checkField("memEn", flagAt(e, 2), 32'(memEn));
        checkField("memRead", flagAt(e, 3), 32'(memRead));
        checkField("memWrite", flagAt(e, 4), 32'(memWrite));
        checkField("memToReg", flagAt(e, 5), 32'(memToReg));
        checkField("regWen", flagAt(e, 6), 32'(regWen));
        checkField("linkPc8", flagAt(e, 7), 32'(linkPc8));
        checkField("undefinedInst", flagAt(e, 8), 32'(undefinedInst));
    endtask

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin : stimulus
        int i;
        arstN      = 1'b0;
        instr      = '0;
        instrValid = 1'b0;
        $readmemh("dv/decodeTrace.txt", traceMem);
        repeat (4) @(posedge clk);
        #1;
        arstN = 1'b1;
        for (i = 0; i < traceLen; i++) begin
            instr      = traceField(i, 0);
            instrValid = 1'b1;
            @(negedge clk);
            while (!instrReady) @(negedge clk);  // fetch holds its word
            @(posedge clk);
            #1;
        end
        instrValid = 1'b0;
        instr      = '0;
        wait (checked == traceLen);
        repeat (4) @(posedge clk);  // nothing extra may come out
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // samples at the falling edge where every DUT output is settled
    initial begin : monitor
        logic xferNow;
        modelCredits = QueueDepth;
        inQueue      = 0;
        accepted     = 0;
        checked      = 0;
        xferPrev     = 1'b0;
        forever begin
            @(negedge clk);
            if (!arstN) begin
                checkField("decValid", 32'h0, 32'(decValid));
                checkField("instrReady", 32'h1, 32'(instrReady));
                modelCredits = QueueDepth;
                xferPrev     = 1'b0;
            end else begin
                checkField("decValid", 32'(xferPrev), 32'(decValid));
                if (decValid) begin
                    assert (checked < traceLen)
                    else failRun("decoded item came out with no trace entry left");
                    checkBundle(checked);
                    checked++;
                    inQueue++;
                    assert (inQueue <= QueueDepth)
                    else failRun("more items outstanding than the queue depth");
                end
                checkField("instrReady", 32'(modelCredits != 0), 32'(instrReady));
                xferNow = instrValid && instrReady;
                if (xferNow) accepted++;
                modelCredits = modelCredits - int'(xferNow) + int'(creditReturn);
                xferPrev     = xferNow;
            end
        end
    end

    initial begin : queueModel
        logic [31:0] r;
        creditReturn = 1'b0;
        rngState     = 32'hfd97_025b;
        returned     = 0;
        @(posedge arstN);
        forever begin
            @(posedge clk);
            #1;
            creditReturn = 1'b0;
            r = nextRand();
            // hold every credit until the queue first fills
            if (inQueue > 0 && (returned > 0 || inQueue == QueueDepth) && r[2:0] > 3'd2) begin
                if (returned == 0) begin
                    assert (accepted == QueueDepth)
                    else failRun("wrong number of transfers before the first credit return");
                end
                creditReturn = 1'b1;
                inQueue--;
                returned++;
            end
        end
    end

    initial begin : watchdog
        #(20 * traceLen * clkPeriod);
        failRun($sformatf("timeout with %0d of %0d trace entries decoded", checked, traceLen));
    end

endmodule

`default_nettype wire

/* hdl/decodeTop.sv */
`default_nettype none

module decodeTop #(
    parameter int QueueDepth = 4
) (
    input  wire logic                                  clk,
    input  wire logic                                  arstN,
    input  wire logic [mipsIsaPkg::instrWidth-1:0]     instr,
    input  wire logic                                  instrValid,
    output logic                                       instrReady,
    input  wire logic                                  creditReturn,
    output logic                                       decValid,
    output decodeCtrlPkg::aluOpE                       aluOp,
    output logic                                       aluSelA,
    output logic                                       aluSelB,
    output logic                                       memEn,
    output logic                                       memRead,
    output logic                                       memWrite,
    output logic                                       memToReg,
    output logic                                       regWen,
    output logic      [mipsIsaPkg::regAddrWidth-1:0]   regWaddr,
    output logic      [mipsIsaPkg::regAddrWidth-1:0]   rsAddr,
    output logic      [mipsIsaPkg::regAddrWidth-1:0]   rtAddr,
    output logic      [mipsIsaPkg::shamtWidth-1:0]     shamt,
    output logic      [decodeCtrlPkg::dataWidth-1:0]   immExt,
    output decodeCtrlPkg::branchTypeE                  branchType,
    output logic                                       linkPc8,
    output logic                                       undefinedInst
);
    import mipsIsaPkg::*;
    import decodeCtrlPkg::*;

    // combinational decode of the incoming word
    aluOpE                   aluOpDec;
    logic                    aluSelADec;
    logic                    aluSelBDec;
    logic                    memEnDec;
    logic                    memReadDec;
    logic                    memWriteDec;
    logic                    memToRegDec;
    logic                    regWenDec;
    logic                    undefinedInstDec;
    logic [regAddrWidth-1:0] rsAddrDec;
    logic [regAddrWidth-1:0] rtAddrDec;
    logic [regAddrWidth-1:0] regWaddrDec;
    branchTypeE              branchTypeDec;
    logic                    linkPc8Dec;

    aluCtrlDecode aluCtrlDecode0 (
        .instr         (instr),
        .aluOp         (aluOpDec),
        .aluSelA       (aluSelADec),
        .aluSelB       (aluSelBDec),
        .memEn         (memEnDec),
        .memRead       (memReadDec),
        .memWrite      (memWriteDec),
        .memToReg      (memToRegDec),
        .regWen        (regWenDec),
        .undefinedInst (undefinedInstDec)
    );

    regFlowDecode regFlowDecode0 (
        .instr      (instr),
        .rsAddr     (rsAddrDec),
        .rtAddr     (rtAddrDec),
        .regWaddr   (regWaddrDec),
        .branchType (branchTypeDec),
        .linkPc8    (linkPc8Dec)
    );

    decodeIssue #(
        .QueueDepth (QueueDepth)
    ) decodeIssue0 (
        .clk              (clk),
        .arstN            (arstN),
        .instr            (instr),
        .instrValid       (instrValid),
        .creditReturn     (creditReturn),
        .aluOpDec         (aluOpDec),
        .aluSelADec       (aluSelADec),
        .aluSelBDec       (aluSelBDec),
        .memEnDec         (memEnDec),
        .memReadDec       (memReadDec),
        .memWriteDec      (memWriteDec),
        .memToRegDec      (memToRegDec),
        .regWenDec        (regWenDec),
        .undefinedInstDec (undefinedInstDec),
        .rsAddrDec        (rsAddrDec),
        .rtAddrDec        (rtAddrDec),
        .regWaddrDec      (regWaddrDec),
        .branchTypeDec    (branchTypeDec),
        .linkPc8Dec       (linkPc8Dec),
        .instrReady       (instrReady),
        .decValid         (decValid),
        .aluOp            (aluOp),
        .aluSelA          (aluSelA),
        .aluSelB          (aluSelB),
        .memEn            (memEn),
        .memRead          (memRead),
        .memWrite         (memWrite),
        .memToReg         (memToReg),
        .regWen           (regWen),
        .regWaddr         (regWaddr),
        .rsAddr           (rsAddr),
        .rtAddr           (rtAddr),
        .shamt            (shamt),
        .immExt           (immExt),
        .branchType       (branchType),
        .linkPc8          (linkPc8),
        .undefinedInst    (undefinedInst)
    );

endmodule

`default_nettype wire

/* hdl/decodeIssue.sv */
`default_nettype none

module decodeIssue #(
    parameter int QueueDepth = 4
) (
    input  wire logic                                  clk,
    input  wire logic                                  arstN,
    input  wire logic [mipsIsaPkg::instrWidth-1:0]     instr,
    input  wire logic                                  instrValid,
    input  wire logic                                  creditReturn,
    input  wire decodeCtrlPkg::aluOpE                  aluOpDec,
    input  wire logic                                  aluSelADec,
    input  wire logic                                  aluSelBDec,
    input  wire logic                                  memEnDec,
    input  wire logic                                  memReadDec,
    input  wire logic                                  memWriteDec,
    input  wire logic                                  memToRegDec,
    input  wire logic                                  regWenDec,
    input  wire logic                                  undefinedInstDec,
    input  wire logic [mipsIsaPkg::regAddrWidth-1:0]   rsAddrDec,
    input  wire logic [mipsIsaPkg::regAddrWidth-1:0]   rtAddrDec,
    input  wire logic [mipsIsaPkg::regAddrWidth-1:0]   regWaddrDec,
    input  wire decodeCtrlPkg::branchTypeE             branchTypeDec,
    input  wire logic                                  linkPc8Dec,
    output logic                                       instrReady,
    output logic                                       decValid,
    output decodeCtrlPkg::aluOpE                       aluOp,
    output logic                                       aluSelA,
    output logic                                       aluSelB,
    output logic                                       memEn,
    output logic                                       memRead,
    output logic                                       memWrite,
    output logic                                       memToReg,
    output logic                                       regWen,
    output logic      [mipsIsaPkg::regAddrWidth-1:0]   regWaddr,
    output logic      [mipsIsaPkg::regAddrWidth-1:0]   rsAddr,
    output logic      [mipsIsaPkg::regAddrWidth-1:0]   rtAddr,
    output logic      [mipsIsaPkg::shamtWidth-1:0]     shamt,
    output logic      [decodeCtrlPkg::dataWidth-1:0]   immExt,
    output decodeCtrlPkg::branchTypeE                  branchType,
    output logic                                       linkPc8,
    output logic                                       undefinedInst
);
    import mipsIsaPkg::*;
    import decodeCtrlPkg::*;

    localparam int cntWidth = $clog2(QueueDepth + 1);

    logic [cntWidth-1:0] credits;
    logic                xfer;
    logic [immWidth-1:0] imm;
    logic                zeroExt;

    assign xfer       = instrValid && instrReady;
    assign instrReady = (credits != '0);
    assign imm        = instr[immWidth-1:0];
    assign zeroExt    = (instr[29:28] == 2'b11);  // andi, ori, xori, lui

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            credits  <= cntWidth'(QueueDepth);
            decValid <= 1'b0;
        end else begin
            decValid <= xfer;
            if (xfer && !creditReturn) begin
                credits <= credits - 1'b1;
            end else if (creditReturn && !xfer && credits != cntWidth'(QueueDepth)) begin
                credits <= credits + 1'b1;  // saturates at queue depth
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            aluOp         <= aluOpDec;
            aluSelA       <= aluSelADec;
            aluSelB       <= aluSelBDec;
            memEn         <= memEnDec;
            memRead       <= memReadDec;
            memWrite      <= memWriteDec;
            memToReg      <= memToRegDec;
            regWen        <= regWenDec;
            regWaddr      <= regWaddrDec;
            rsAddr        <= rsAddrDec;
            rtAddr        <= rtAddrDec;
            shamt         <= instr[10:6];
            immExt        <= zeroExt ? {{(dataWidth-immWidth){1'b0}}, imm}
                                     : {{(dataWidth-immWidth){imm[immWidth-1]}}, imm};
            branchType    <= branchTypeDec;
            linkPc8       <= linkPc8Dec;
            undefinedInst <= undefinedInstDec;
        end
    end

endmodule

`default_nettype wire

/* hdl/regFlowDecode.sv */
`default_nettype none

module regFlowDecode (
    input  wire logic [mipsIsaPkg::instrWidth-1:0]   instr,
    output logic      [mipsIsaPkg::regAddrWidth-1:0] rsAddr,
    output logic      [mipsIsaPkg::regAddrWidth-1:0] rtAddr,
    output logic      [mipsIsaPkg::regAddrWidth-1:0] regWaddr,
    output decodeCtrlPkg::branchTypeE                branchType,
    output logic                                     linkPc8
);
    import mipsIsaPkg::*;
    import decodeCtrlPkg::*;

    opcodeE opcode;
    functE  funct;
    regimmE rtSel;

    assign opcode = opcodeE'(instr[31:26]);
    assign funct  = functE'(instr[5:0]);
    assign rtSel  = regimmE'(instr[20:16]);

    always_comb begin
        rsAddr     = instr[25:21];
        rtAddr     = instr[20:16];
        regWaddr   = instr[15:11];  // rd
        branchType = btNop;
        linkPc8    = 1'b0;
        case (opcode)
            opSpecial: begin
                if (funct == fnJr || funct == fnJalr) begin
                    branchType = btJreg;
                    linkPc8    = (funct == fnJalr);
                end
            end
            opLb, opLh, opLw, opLbu, opLhu,
            opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
                regWaddr = instr[20:16];  // rt is the destination
                rtAddr   = '0;
            end
            opJ, opJal: begin
                rsAddr     = '0;
                rtAddr     = '0;
                branchType = btJ;
                if (opcode == opJal) begin
                    linkPc8  = 1'b1;
                    regWaddr = linkReg;
                end
            end
            opBeq:  branchType = btBeq;
            opBne:  branchType = btBne;
            opBgtz: branchType = btBgtz;
            opBlez: branchType = btBlez;
            opRegimm: begin
                case (rtSel)
                    rtBgez, rtBgezal: branchType = btBgez;
                    rtBltz, rtBltzal: branchType = btBltz;
                    default:          branchType = btNop;
                endcase
                if (rtSel == rtBgezal || rtSel == rtBltzal) begin
                    linkPc8  = 1'b1;
                    regWaddr = linkReg;
                    rtAddr   = '0;  // rt only selects the condition
                end
            end
            default: branchType = btNop;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/aluCtrlDecode.sv */
`default_nettype none

module aluCtrlDecode (
    input  wire logic [mipsIsaPkg::instrWidth-1:0] instr,
    output decodeCtrlPkg::aluOpE                   aluOp,
    output logic                                   aluSelA,
    output logic                                   aluSelB,
    output logic                                   memEn,
    output logic                                   memRead,
    output logic                                   memWrite,
    output logic                                   memToReg,
    output logic                                   regWen,
    output logic                                   undefinedInst
);
    import mipsIsaPkg::*;
    import decodeCtrlPkg::*;

    opcodeE opcode;
    functE  funct;
    regimmE rtSel;

    assign opcode = opcodeE'(instr[31:26]);
    assign funct  = functE'(instr[5:0]);
    assign rtSel  = regimmE'(instr[20:16]);

    always_comb begin
        aluOp         = aluNop;
        aluSelA       = 1'b0;
        aluSelB       = 1'b0;
        memEn         = 1'b0;
        memRead       = 1'b0;
        memWrite      = 1'b0;
        memToReg      = 1'b0;
        regWen        = 1'b0;
        undefinedInst = 1'b0;
        case (opcode)
            opSpecial: begin
                regWen = 1'b1;
                case (funct)
                    fnAnd:  aluOp = aluAnd;
                    fnOr:   aluOp = aluOr;
                    fnXor:  aluOp = aluXor;
                    fnNor:  aluOp = aluNor;
                    fnSlt:  aluOp = aluSlt;
                    fnSltu: aluOp = aluSltu;
                    fnAdd:  aluOp = aluAdd;
                    fnAddu: aluOp = aluAddu;
                    fnSub:  aluOp = aluSub;
                    fnSubu: aluOp = aluSubu;
                    fnSllv: aluOp = aluSllv;
                    fnSrlv: aluOp = aluSrlv;
                    fnSrav: aluOp = aluSrav;
                    fnSll, fnSrl, fnSra: begin
                        aluSelA = 1'b1;  // shift amount from shamt
                        aluOp   = (funct == fnSll) ? aluSll :
                                  (funct == fnSrl) ? aluSrl : aluSra;
                    end
                    fnJr:   regWen = 1'b0;
                    fnJalr: aluOp = aluNop;  // rd <= pc+8
                    default: begin
                        regWen        = 1'b0;
                        undefinedInst = 1'b1;
                    end
                endcase
            end
            opLb, opLh, opLw, opLbu, opLhu: begin
                aluOp    = aluAddu;  // base + offset
                aluSelB  = 1'b1;
                memEn    = 1'b1;
                memRead  = 1'b1;
                memToReg = 1'b1;
                regWen   = 1'b1;
            end
            opSb, opSh, opSw: begin
                aluOp    = aluAddu;
                aluSelB  = 1'b1;
                memEn    = 1'b1;
                memWrite = 1'b1;
            end
            opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
                aluSelB = 1'b1;
                regWen  = 1'b1;
                case (opcode)
                    opAddi:  aluOp = aluAdd;
                    opAddiu: aluOp = aluAddu;
                    opSlti:  aluOp = aluSlt;
                    opSltiu: aluOp = aluSltu;
                    opAndi:  aluOp = aluAnd;
                    opOri:   aluOp = aluOr;
                    opXori:  aluOp = aluXor;
                    default: aluOp = aluLui;
                endcase
            end
            opJ, opBeq, opBne, opBlez, opBgtz: aluOp = aluNop;
            opJal: regWen = 1'b1;
            opRegimm: begin
                case (rtSel)
                    rtBgezal, rtBltzal: regWen = 1'b1;
                    rtBgez, rtBltz:     aluOp = aluNop;
                    default:            undefinedInst = 1'b1;
                endcase
            end
            default: undefinedInst = 1'b1;  // cop0, special2 and the rest
        endcase
    end

endmodule

`default_nettype wire

/* hdl/decodeCtrlPkg.sv */
`default_nettype none

package decodeCtrlPkg;

    localparam int dataWidth       = 32;
    localparam int aluOpWidth      = 5;
    localparam int branchTypeWidth = 4;

    typedef enum logic [aluOpWidth-1:0] {
        aluNop,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSltu,
        aluAdd,
        aluAddu,
        aluSub,
        aluSubu,
        aluSll,
        aluSllv,
        aluSrl,
        aluSrlv,
        aluSra,
        aluSrav,
        aluLui
    } aluOpE;

    typedef enum logic [branchTypeWidth-1:0] {
        btNop,
        btJ,
        btJreg,  // target from rs
        btBeq,
        btBne,
        btBgtz,
        btBlez,
        btBgez,
        btBltz
    } branchTypeE;

endpackage

`default_nettype wire

/* hdl/mipsIsaPkg.sv */
`default_nettype none

package mipsIsaPkg;

    localparam int instrWidth   = 32;
    localparam int regAddrWidth = 5;
    localparam int immWidth     = 16;
    localparam int opWidth      = 6;
    localparam int functWidth   = 6;
    localparam int shamtWidth   = 5;

    localparam logic [regAddrWidth-1:0] linkReg = 5'd31;  // receives pc+8

    // major opcodes in instr[31:26]
    typedef enum logic [opWidth-1:0] {
        opSpecial = 6'b000000,
        opRegimm  = 6'b000001,
        opJ       = 6'b000010,
        opJal     = 6'b000011,
        opBeq     = 6'b000100,
        opBne     = 6'b000101,
        opBlez    = 6'b000110,
        opBgtz    = 6'b000111,
        opAddi    = 6'b001000,
        opAddiu   = 6'b001001,
        opSlti    = 6'b001010,
        opSltiu   = 6'b001011,
        opAndi    = 6'b001100,
        opOri     = 6'b001101,
        opXori    = 6'b001110,
        opLui     = 6'b001111,
        opLb      = 6'b100000,
        opLh      = 6'b100001,
        opLw      = 6'b100011,
        opLbu     = 6'b100100,
        opLhu     = 6'b100101,
        opSb      = 6'b101000,
        opSh      = 6'b101001,
        opSw      = 6'b101011
    } opcodeE;

    typedef enum logic [functWidth-1:0] {
        fnSll  = 6'b000000,
        fnSrl  = 6'b000010,
        fnSra  = 6'b000011,
        fnSllv = 6'b000100,
        fnSrlv = 6'b000110,
        fnSrav = 6'b000111,
        fnJr   = 6'b001000,
        fnJalr = 6'b001001,
        fnAdd  = 6'b100000,
        fnAddu = 6'b100001,
        fnSub  = 6'b100010,
        fnSubu = 6'b100011,
        fnAnd  = 6'b100100,
        fnOr   = 6'b100101,
        fnXor  = 6'b100110,
        fnNor  = 6'b100111,
        fnSlt  = 6'b101010,
        fnSltu = 6'b101011
    } functE;

    typedef enum logic [regAddrWidth-1:0] {  // sits in the rt field
        rtBltz   = 5'b00000,
        rtBgez   = 5'b00001,
        rtBltzal = 5'b10000,
        rtBgezal = 5'b10001
    } regimmE;

endpackage

`default_nettype wire
